// File: Makefile
# Verilator build and run for the instruction cache testbench.

SIM        = verilator
TOP        = tb_icache
FILELIST   = icache.f
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing
OBJ_DIR    = obj_dir

SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES) include/icache_config.svh
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# a $fatal in the testbench makes the binary exit with a failing status.
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: hw/fsab_pkg.sv
// ############################
// FSAB split-transaction bus types.
// ############################

package fsab_pkg;

	// request mode carried on the outbound channel.
	// The cache only ever issues reads.
	typedef enum logic [1:0] {
		FSAB_READ  = 2'b00,
		FSAB_WRITE = 2'b01
	} fsab_mode_t;

	// device and sub-device IDs share one width.
	// A response is routed back by the pair of IDs of its requester.
	typedef logic [3:0] fsab_did_t;

	// byte address on the bus.
	// The bus space is 2 GB, so the top core address bit is dropped.
	typedef logic [30:0] fsab_addr_t;

	// number of beats in one transaction.
	typedef logic [3:0] fsab_len_t;

	// one data beat.
	typedef logic [63:0] fsab_data_t;

	// byte enables for one beat, used on writes.
	typedef logic [7:0] fsab_mask_t;

endpackage

// File: hw/fsab_port.sv
// ############################
// FSAB bus port with credit count and response ID filter.
// ############################

`timescale 1ns/100ps
`include "icache_config.svh"

module fsab_port (
	input  logic                  clk,
	input  logic                  Nrst,
	fsab_req_if.port              req,
	input  logic                  fsab_credit,
	input  logic                  fsabi_valid,
	input  fsab_pkg::fsab_did_t   fsabi_did,
	input  fsab_pkg::fsab_did_t   fsabi_subdid,
	input  fsab_pkg::fsab_data_t  fsabi_data,
	output logic                  fsabo_valid,
	output fsab_pkg::fsab_mode_t  fsabo_mode,
	output fsab_pkg::fsab_did_t   fsabo_did,
	output fsab_pkg::fsab_did_t   fsabo_subdid,
	output fsab_pkg::fsab_addr_t  fsabo_addr,
	output fsab_pkg::fsab_len_t   fsabo_len,
	output logic                  credit_avail,
	output logic                  resp_valid,
	output fsab_pkg::fsab_data_t  resp_data
);
	localparam logic [`FSAB_CREDITS_W-1:0] CREDITS_INIT = `FSAB_INITIAL_CREDITS;

	logic [`FSAB_CREDITS_W-1:0] credit_cnt;

	// every request is one cycle long, so one pulse spends exactly one credit.
	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			credit_cnt <= CREDITS_INIT;
		end else begin
			case ({fsab_credit, req.valid})
				2'b10:   credit_cnt <= credit_cnt + 1'b1;
				2'b01:   credit_cnt <= credit_cnt - 1'b1;
				default: credit_cnt <= credit_cnt;
			endcase
		end
	end

	// a credit returned this cycle is usable from the next one.
	assign credit_avail = (credit_cnt != '0);

	// the request fields are held at zero between requests.
	always_comb begin
		fsabo_valid  = req.valid;
		fsabo_mode   = fsab_pkg::fsab_mode_t'(0);
		fsabo_did    = '0;
		fsabo_subdid = '0;
		fsabo_addr   = '0;
		fsabo_len    = '0;
		if (req.valid) begin
			fsabo_mode   = req.mode;
			fsabo_did    = req.did;
			fsabo_subdid = req.subdid;
			fsabo_addr   = req.addr;
			fsabo_len    = req.len;
		end
	end

	// responses to other devices share the inbound channel.
	assign resp_valid = fsabi_valid &&
		(fsabi_did == fsab_pkg::fsab_did_t'(`FSAB_DID_CPU)) &&
		(fsabi_subdid == fsab_pkg::fsab_did_t'(`FSAB_SUBDID_ICACHE));
	assign resp_data = fsabi_data;

	// the bus only returns credits it was given, so a count above the reset
	// value means the counter wrapped below zero or a credit came back twice.
	a_no_underflow: assert property (
		@(posedge clk) disable iff (!Nrst)
		credit_cnt <= CREDITS_INIT
	) else $error("fsab credit count left its range");

endmodule

// File: hw/icache_fill.sv
// ############################
// Miss detection and line fill control for the instruction cache.
// ############################

`timescale 1ns/100ps
`include "icache_config.svh"

module icache_fill (
	input  logic                  clk,
	input  logic                  Nrst,
	input  icache_pkg::cpu_addr_t rd_addr,
	input  logic                  rd_req,
	input  logic                  hit,
	input  logic                  credit_avail,
	input  logic                  resp_valid,
	input  fsab_pkg::fsab_data_t  resp_data,
	fsab_req_if.requester         req,
	icache_fill_if.source         fill
);
	localparam int OFF_W = $clog2(`ICACHE_LINE_BYTES);
	localparam icache_pkg::ic_beat_t LAST_BEAT = icache_pkg::ic_beat_t'(`FSAB_BEATS - 1);

	logic                  read_pending;
	logic                  start_read;
	logic                  last_beat;
	icache_pkg::cpu_addr_t miss_line;
	icache_pkg::cpu_addr_t fill_line;
	icache_pkg::ic_beat_t  fill_pos;

	// line-aligned address of the fetch that missed.
	assign miss_line = {rd_addr[31:OFF_W], {OFF_W{1'b0}}};

	// only one line read is in flight, so a second miss waits for the fill.
	assign start_read = rd_req && !hit && !read_pending && credit_avail;
	assign last_beat  = resp_valid && (fill_pos == LAST_BEAT);

	assign req.valid  = start_read;
	assign req.mode   = fsab_pkg::FSAB_READ;
	assign req.did    = fsab_pkg::fsab_did_t'(`FSAB_DID_CPU);
	assign req.subdid = fsab_pkg::fsab_did_t'(`FSAB_SUBDID_ICACHE);
	assign req.addr   = miss_line[30:0];
	assign req.len    = fsab_pkg::fsab_len_t'(`FSAB_BEATS);

	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			read_pending <= 1'b0;
			fill_pos     <= '0;
		end else if (start_read) begin
			read_pending <= 1'b1;
			fill_pos     <= '0;
		end else if (resp_valid) begin
			fill_pos <= fill_pos + 1'b1;
			if (last_beat) begin
				read_pending <= 1'b0;
			end
		end
	end

	// the core holds its address during the stall, but the fill uses its own copy.
	always_ff @(posedge clk) begin
		if (start_read) begin
			fill_line <= miss_line;
		end
	end

	// beats arrive in address order, one word pair per beat.
	assign fill.we   = resp_valid;
	assign fill.idx  = icache_pkg::addr_idx(fill_line);
	assign fill.beat = fill_pos;
	assign fill.data = resp_data;
	assign fill.done = last_beat;
	assign fill.tag  = icache_pkg::addr_tag(fill_line);

	// the bus port passes only beats addressed to the cache.
	a_resp_needs_read: assert property (
		@(posedge clk) disable iff (!Nrst)
		resp_valid |-> read_pending
	) else $error("icache fill beat arrived with no read pending");

endmodule

// File: hw/icache_ifs.sv
// ############################
// Interfaces between the cache blocks.
// ############################

`timescale 1ns/100ps

// outbound FSAB request from the fill control to the bus port.
// valid is a one-cycle pulse and each pulse spends one credit.
interface fsab_req_if ();
	logic                 valid;
	fsab_pkg::fsab_mode_t mode;
	fsab_pkg::fsab_did_t  did;
	fsab_pkg::fsab_did_t  subdid;
	fsab_pkg::fsab_addr_t addr;
	fsab_pkg::fsab_len_t  len;

	modport requester (output valid, mode, did, subdid, addr, len);

	modport port (input valid, mode, did, subdid, addr, len);
endinterface

// fill writes from the fill control into the lookup arrays.
// we writes one beat, and done on the last beat installs the tag.
interface icache_fill_if ();
	logic                  we;
	icache_pkg::ic_idx_t   idx;
	icache_pkg::ic_beat_t  beat;
	fsab_pkg::fsab_data_t  data;
	logic                  done;
	icache_pkg::ic_tag_t   tag;

	modport source (output we, idx, beat, data, done, tag);

	modport sink (input we, idx, beat, data, done, tag);
endinterface

// File: hw/icache_lookup.sv
// ############################
// Instruction cache lookup with tag compare and registered read port.
// ############################

`timescale 1ns/100ps
`include "icache_config.svh"

module icache_lookup (
	input  logic                  clk,
	input  logic                  Nrst,
	input  icache_pkg::cpu_addr_t rd_addr,
	input  logic                  rd_req,
	output logic                  rd_wait,
	output icache_pkg::cpu_word_t rd_data,
	icache_fill_if.sink           fill,
	output logic                  hit
);
	// each half array holds one word per beat of every line.
	localparam int WORDS = `ICACHE_LINES * `FSAB_BEATS;

	logic [`ICACHE_LINES-1:0] line_valid;
	icache_pkg::ic_tag_t      line_tag [`ICACHE_LINES];
	icache_pkg::cpu_word_t    data_hi [WORDS];
	icache_pkg::cpu_word_t    data_lo [WORDS];

	icache_pkg::ic_tag_t      rd_tag;
	icache_pkg::ic_idx_t      rd_idx;
	icache_pkg::ic_beat_t     rd_beat;
	logic [$clog2(WORDS)-1:0] rd_word;
	logic [$clog2(WORDS)-1:0] fill_word;

	assign rd_tag  = icache_pkg::addr_tag(rd_addr);
	assign rd_idx  = icache_pkg::addr_idx(rd_addr);
	assign rd_beat = icache_pkg::addr_beat(rd_addr);

	// word arrays are addressed by line index and beat together.
	assign rd_word   = {rd_idx, rd_beat};
	assign fill_word = {fill.idx, fill.beat};

	assign hit     = line_valid[rd_idx] && (line_tag[rd_idx] == rd_tag);
	assign rd_wait = rd_req && !hit;

	// a line stays invalid from its first fill beat until the last one lands.
	always_ff @(posedge clk or negedge Nrst) begin
		if (!Nrst) begin
			line_valid <= '0;
		end else if (fill.done) begin
			line_valid[fill.idx] <= 1'b1;
		end else if (fill.we && (fill.beat == '0)) begin
			line_valid[fill.idx] <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (fill.done) begin
			line_tag[fill.idx] <= fill.tag;
		end
	end

	// the high half of the beat is the word at the higher address.
	always_ff @(posedge clk) begin
		if (fill.we) begin
			data_hi[fill_word] <= fill.data[63:32];
			data_lo[fill_word] <= fill.data[31:0];
		end
	end

	// the word comes back one clock after the hit is seen.
	always_ff @(posedge clk) begin
		if (rd_req && hit) begin
			if (icache_pkg::addr_hi(rd_addr)) begin
				rd_data <= data_hi[rd_word];
			end else begin
				rd_data <= data_lo[rd_word];
			end
		end
	end

	// a valid line must have had all of its beats written by the fill.
	a_hit_data_known: assert property (
		@(posedge clk) disable iff (!Nrst)
		rd_req && hit |=> !$isunknown(rd_data)
	) else $error("icache read returned unknown data after a hit");

endmodule

// File: hw/icache_pkg.sv
// ############################
// Instruction cache types and address field helpers.
// ############################

package icache_pkg;

	typedef logic [31:0] cpu_addr_t;
	typedef logic [31:0] cpu_word_t;

	// core address layout is tag [31:10], index [9:6], beat [5:3].
	// Bit 2 picks the high or low word of a beat.
	typedef logic [21:0] ic_tag_t;
	typedef logic [3:0]  ic_idx_t;
	typedef logic [2:0]  ic_beat_t;

	function automatic ic_tag_t addr_tag(cpu_addr_t addr);
		return addr[31:10];
	endfunction

	function automatic ic_idx_t addr_idx(cpu_addr_t addr);
		return addr[9:6];
	endfunction

	function automatic ic_beat_t addr_beat(cpu_addr_t addr);
		return addr[5:3];
	endfunction

	// high word of a beat sits at the odd word address.
	function automatic logic addr_hi(cpu_addr_t addr);
		return addr[2];
	endfunction

endpackage

// File: hw/icache_top.sv
// ############################
// Instruction cache top level on the FSAB bus.
// ############################

`timescale 1ns/100ps

module icache_top (
	input  logic                  clk,
	input  logic                  Nrst,
	input  icache_pkg::cpu_addr_t rd_addr,
	input  logic                  rd_req,
	output logic                  rd_wait,
	output icache_pkg::cpu_word_t rd_data,
	input  logic                  fsab_credit,
	input  logic                  fsabi_valid,
	input  fsab_pkg::fsab_did_t   fsabi_did,
	input  fsab_pkg::fsab_did_t   fsabi_subdid,
	input  fsab_pkg::fsab_data_t  fsabi_data,
	output logic                  fsabo_valid,
	output fsab_pkg::fsab_mode_t  fsabo_mode,
	output fsab_pkg::fsab_did_t   fsabo_did,
	output fsab_pkg::fsab_did_t   fsabo_subdid,
	output fsab_pkg::fsab_addr_t  fsabo_addr,
	output fsab_pkg::fsab_len_t   fsabo_len
);
	logic                 hit;
	logic                 credit_avail;
	logic                 resp_valid;
	fsab_pkg::fsab_data_t resp_data;

	fsab_req_if    req_bus ();
	icache_fill_if fill_bus ();

	icache_lookup icache_lookup_i (
		.clk(clk), .Nrst(Nrst), .rd_addr(rd_addr), .rd_req(rd_req),
		.rd_wait(rd_wait), .rd_data(rd_data), .fill(fill_bus), .hit(hit)
	);

	// the fill control sees the same fetch as the lookup in the same cycle.
	icache_fill icache_fill_i (
		.clk(clk), .Nrst(Nrst), .rd_addr(rd_addr), .rd_req(rd_req), .hit(hit),
		.credit_avail(credit_avail), .resp_valid(resp_valid), .resp_data(resp_data),
		.req(req_bus), .fill(fill_bus)
	);

	fsab_port fsab_port_i (
		.clk(clk), .Nrst(Nrst), .req(req_bus), .fsab_credit(fsab_credit),
		.fsabi_valid(fsabi_valid), .fsabi_did(fsabi_did), .fsabi_subdid(fsabi_subdid),
		.fsabi_data(fsabi_data), .fsabo_valid(fsabo_valid), .fsabo_mode(fsabo_mode),
		.fsabo_did(fsabo_did), .fsabo_subdid(fsabo_subdid), .fsabo_addr(fsabo_addr),
		.fsabo_len(fsabo_len), .credit_avail(credit_avail), .resp_valid(resp_valid),
		.resp_data(resp_data)
	);

endmodule

// File: icache.f
+incdir+include
hw/fsab_pkg.sv
hw/icache_pkg.sv
hw/icache_ifs.sv
hw/icache_lookup.sv
hw/icache_fill.sv
hw/fsab_port.sv
hw/icache_top.sv
test/tb_icache.sv

// File: include/icache_config.svh
// ############################
// Instruction cache and FSAB bus configuration constants.
// ############################

`ifndef ICACHE_CONFIG_SVH
`define ICACHE_CONFIG_SVH

// cache geometry, direct mapped.
`define ICACHE_LINES 16

// bytes held by one cache line.
`define ICACHE_LINE_BYTES 64

// 64-bit beats needed to move one line over the bus.
`define FSAB_BEATS 8

// credits the bus grants the cache out of reset.
`define FSAB_INITIAL_CREDITS 4

// width of the credit counter, wide enough for every returned credit.
`define FSAB_CREDITS_W 3

// device ID of the CPU on the bus.
`define FSAB_DID_CPU 1

// sub-device ID of the instruction cache within the CPU.
`define FSAB_SUBDID_ICACHE 0

`endif

// File: test/tb_icache.sv
// ############################
// Testbench for the instruction cache with an FSAB memory model.
// ############################

`timescale 1ns/100ps
`include "icache_config.svh"

module tb_icache;

	typedef struct packed {
		icache_pkg::cpu_addr_t addr;
		logic                  exp_hit;
		logic                  noise;
		logic                  hold;
		logic                  starve;
	} fetch_t;

	localparam int N_FETCH = 22;
	localparam int GAP     = 3;

	// columns are address, expected hit, foreign beats, credits held, request starved.
	localparam fetch_t FETCHES [N_FETCH] = '{
		'{32'h0000_1040, 1'b0, 1'b0, 1'b0, 1'b0},
		'{32'h0000_1040, 1'b1, 1'b0, 1'b0, 1'b0},
		'{32'h0000_107C, 1'b1, 1'b0, 1'b0, 1'b0},
		'{32'h0000_1044, 1'b1, 1'b0, 1'b0, 1'b0},
		'{32'h0000_2080, 1'b0, 1'b0, 1'b0, 1'b0},
		'{32'h0000_30C8, 1'b0, 1'b1, 1'b0, 1'b0},
		'{32'h0000_30F4, 1'b1, 1'b0, 1'b0, 1'b0},
		'{32'h0000_1040, 1'b1, 1'b0, 1'b0, 1'b0},
		'{32'h0000_2084, 1'b1, 1'b0, 1'b0, 1'b0},
		'{32'h0000_5040, 1'b0, 1'b0, 1'b0, 1'b0},
		'{32'h0000_5058, 1'b1, 1'b0, 1'b0, 1'b0},
		'{32'h0000_1048, 1'b0, 1'b1, 1'b0, 1'b0},
		'{32'h0000_2088, 1'b1, 1'b0, 1'b0, 1'b0},
		'{32'h0000_0100, 1'b0, 1'b0, 1'b1, 1'b0},
		'{32'h0000_0140, 1'b0, 1'b0, 1'b1, 1'b0},
		'{32'h0000_0180, 1'b0, 1'b0, 1'b1, 1'b0},
		'{32'h0000_01C0, 1'b0, 1'b0, 1'b1, 1'b0},
		'{32'h0000_0200, 1'b0, 1'b0, 1'b1, 1'b1},
		'{32'h0000_0104, 1'b1, 1'b0, 1'b0, 1'b0},
		'{32'h0000_0204, 1'b1, 1'b0, 1'b0, 1'b0},
		'{32'h7FFF_FFFC, 1'b0, 1'b1, 1'b0, 1'b0},
		'{32'h7FFF_FFC0, 1'b1, 1'b0, 1'b0, 1'b0}
	};

	logic                  clk;
	logic                  Nrst;
	icache_pkg::cpu_addr_t rd_addr;
	logic                  rd_req;
	logic                  rd_wait;
	icache_pkg::cpu_word_t rd_data;
	logic                  fsab_credit;
	logic                  fsabi_valid;
	fsab_pkg::fsab_did_t   fsabi_did;
	fsab_pkg::fsab_did_t   fsabi_subdid;
	fsab_pkg::fsab_data_t  fsabi_data;
	logic                  fsabo_valid;
	fsab_pkg::fsab_mode_t  fsabo_mode;
	fsab_pkg::fsab_did_t   fsabo_did;
	fsab_pkg::fsab_did_t   fsabo_subdid;
	fsab_pkg::fsab_addr_t  fsabo_addr;
	fsab_pkg::fsab_len_t   fsabo_len;

	// state of the bus model.
	fsab_pkg::fsab_addr_t req_q [$];
	fsab_pkg::fsab_addr_t last_req_addr;
	int                   req_count    = 0;
	int                   credits_due  = 0;
	logic                 hold_credits = 1'b0;
	logic                 noise_on     = 1'b0;
	logic [31:0]          lcg_state    = 32'd55647;

	icache_top icache_top_i (
		.clk(clk), .Nrst(Nrst), .rd_addr(rd_addr), .rd_req(rd_req), .rd_wait(rd_wait),
		.rd_data(rd_data), .fsab_credit(fsab_credit), .fsabi_valid(fsabi_valid),
		.fsabi_did(fsabi_did), .fsabi_subdid(fsabi_subdid), .fsabi_data(fsabi_data),
		.fsabo_valid(fsabo_valid), .fsabo_mode(fsabo_mode), .fsabo_did(fsabo_did),
		.fsabo_subdid(fsabo_subdid), .fsabo_addr(fsabo_addr), .fsabo_len(fsabo_len)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic logic [31:0] lcg_next(logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic report_failure(string what);
		$display("%s", what);
		$display("sim failed");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(string name, icache_pkg::cpu_word_t got,
			icache_pkg::cpu_word_t exp);
		if (got !== exp) begin
			report_failure($sformatf("[FAIL] %s = 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_addr(string name, fsab_pkg::fsab_addr_t got,
			fsab_pkg::fsab_addr_t exp);
		if (got !== exp) begin
			report_failure($sformatf("[FAIL] %s = 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_bit(string name, logic got, logic exp);
		if (got !== exp) begin
			report_failure($sformatf("[FAIL] %s = 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_id(string name, fsab_pkg::fsab_did_t got, fsab_pkg::fsab_did_t exp);
		if (got !== exp) begin
			report_failure($sformatf("[FAIL] %s = 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_len(string name, fsab_pkg::fsab_len_t got, fsab_pkg::fsab_len_t exp);
		if (got !== exp) begin
			report_failure($sformatf("[FAIL] %s = 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	task automatic check_mode(string name, fsab_pkg::fsab_mode_t got,
			fsab_pkg::fsab_mode_t exp);
		if (got !== exp) begin
			report_failure($sformatf("[FAIL] %s = 0x%h, expected 0x%h", name, got, exp));
		end
	endtask

	// every request must be a full line read addressed back to the cache.
	always @(posedge clk) begin
		if (Nrst && fsabo_valid) begin
			check_mode("fsabo_mode", fsabo_mode, fsab_pkg::FSAB_READ);
			check_len("fsabo_len", fsabo_len, fsab_pkg::fsab_len_t'(`FSAB_BEATS));
			check_id("fsabo_did", fsabo_did, fsab_pkg::fsab_did_t'(`FSAB_DID_CPU));
			check_id("fsabo_subdid", fsabo_subdid,
				fsab_pkg::fsab_did_t'(`FSAB_SUBDID_ICACHE));
			req_q.push_back(fsabo_addr);
			last_req_addr = fsabo_addr;
			req_count++;
		end
	end

	// memory model: every word of a line holds its own byte address.
	initial begin : bus_model
		fsab_pkg::fsab_addr_t line;
		logic [31:0]          word;
		int                   beat;
		int                   gap;
		logic                 busy;
		busy = 1'b0;
		beat = 0;
		gap  = 0;
		line = '0;
		fsab_credit  = 1'b0;
		fsabi_valid  = 1'b0;
		fsabi_did    = '0;
		fsabi_subdid = '0;
		fsabi_data   = '0;
		forever begin
			@(negedge clk);
			fsab_credit  = 1'b0;
			fsabi_valid  = 1'b0;
			fsabi_did    = '0;
			fsabi_subdid = '0;
			fsabi_data   = '0;
			if (!hold_credits && credits_due > 0) begin
				fsab_credit = 1'b1;
				credits_due--;
			end
			if (!busy && req_q.size() > 0) begin
				line = req_q.pop_front();
				busy = 1'b1;
				beat = 0;
				gap  = GAP;
			end else if (busy && gap > 0) begin
				gap--;
			end else if (busy) begin
				lcg_state = lcg_next(lcg_state);
				fsabi_valid = 1'b1;
				if (noise_on && lcg_state[16]) begin
					// a beat for another device or another unit of the CPU.
					if (lcg_state[20]) begin
						fsabi_did    = fsab_pkg::fsab_did_t'(`FSAB_DID_CPU + 1);
						fsabi_subdid = lcg_state[27:24];
					end else begin
						fsabi_did    = fsab_pkg::fsab_did_t'(`FSAB_DID_CPU);
						fsabi_subdid = fsab_pkg::fsab_did_t'(`FSAB_SUBDID_ICACHE + 1);
					end
					fsabi_data = {lcg_state, ~lcg_state};
				end else begin
					word         = {1'b0, line} + 32'(8 * beat);
					fsabi_did    = fsab_pkg::fsab_did_t'(`FSAB_DID_CPU);
					fsabi_subdid = fsab_pkg::fsab_did_t'(`FSAB_SUBDID_ICACHE);
					fsabi_data   = {word + 32'd4, word};
					beat++;
					if (beat == `FSAB_BEATS) begin
						busy = 1'b0;
						credits_due++;
					end
				end
			end
		end
	end

	task automatic run_fetch(fetch_t f);
		fsab_pkg::fsab_addr_t exp_line;
		int                   count_before;
		int                   exp_reqs;
		exp_line = {f.addr[30:6], 6'b0};
		exp_reqs = f.exp_hit ? 0 : 1;
		@(negedge clk);
		count_before = req_count;
		rd_addr = f.addr;
		rd_req  = 1'b1;
		@(posedge clk);
		check_bit("rd_wait", rd_wait, !f.exp_hit);
		if (f.starve) begin
			check_bit("fsabo_valid", fsabo_valid, 1'b0);
			repeat (20) begin
				@(posedge clk);
				check_bit("fsabo_valid", fsabo_valid, 1'b0);
				check_bit("rd_wait", rd_wait, 1'b1);
			end
			hold_credits = 1'b0;
		end else if (!f.exp_hit) begin
			check_bit("fsabo_valid", fsabo_valid, 1'b1);
		end
		while (rd_wait) begin
			@(posedge clk);
		end
		@(negedge clk);
		check_word("rd_data", rd_data, f.addr);
		if (req_count != count_before + exp_reqs) begin
			report_failure($sformatf("fetch of 0x%h caused %0d bus requests instead of %0d",
				f.addr, req_count - count_before, exp_reqs));
		end
		if (!f.exp_hit) begin
			check_addr("fsabo_addr", last_req_addr, exp_line);
		end
		@(posedge clk);
	endtask

	initial begin : watchdog
		repeat (N_FETCH * 200) @(posedge clk);
		report_failure("watchdog expired before the fetch table completed");
	end

	initial begin : stimulus
		Nrst    = 1'b0;
		rd_req  = 1'b0;
		rd_addr = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		Nrst = 1'b1;
		@(posedge clk);
		for (int i = 0; i < N_FETCH; i++) begin
			hold_credits = FETCHES[i].hold;
			noise_on     = FETCHES[i].noise;
			run_fetch(FETCHES[i]);
		end
		$display("sim passed");
		$finish;
	end

endmodule
